/* Bender.yml */
package:
  name: idma_port

sources:
  - logic/idmaPkg.sv
  - logic/hostSync.sv
  - logic/idmaSequencer.sv
  - logic/memSteal.sv
  - logic/idmaPort.sv

  - target: test
    files:
      - tb/idmaTb.sv

/* files.f */
logic/idmaPkg.sv
logic/hostSync.sv
logic/idmaSequencer.sv
logic/memSteal.sv
logic/idmaPort.sv
tb/idmaTb.sv

/* logic/hostSync.sv */
`timescale 1ns/1ps
`default_nettype none

module hostSync (
  input  logic                         DSPCLK,
  input  logic                         RST,
  input  logic                         ISn,
  input  logic                         IRDn,
  input  logic                         IWRn,
  input  logic                         IAL,
  input  logic [idmaPkg::hostBits-1:0] IAD,
  output idmaPkg::hostEvt              evt,
  output logic                         readActive
);

  logic rdCmd;
  logic wrCmd;
  logic alCmd;
  logic rdCmdD1;
  logic wrCmdD1;
  logic alCmdD1;
  logic [idmaPkg::hostBits-1:0] iadQ;

  // one register stage on the asynchronous strobes
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      rdCmd   <= 1'b0;
      wrCmd   <= 1'b0;
      alCmd   <= 1'b0;
      rdCmdD1 <= 1'b0;
      wrCmdD1 <= 1'b0;
      alCmdD1 <= 1'b0;
    end else begin
      rdCmd   <= !(ISn || IRDn);
      wrCmd   <= !(ISn || IWRn);
      alCmd   <= !ISn && IAL;
      rdCmdD1 <= rdCmd;
      wrCmdD1 <= wrCmd;
      alCmdD1 <= alCmd;
    end
  end

  // bus sampled whenever the port is selected
  always_ff @(posedge DSPCLK) begin
    if (!ISn) begin
      iadQ <= IAD;
    end
  end

  assign evt.latch = alCmd && !alCmdD1;
  assign evt.rdBeg = rdCmd && !rdCmdD1;
  assign evt.wrBeg = wrCmd && !wrCmdD1;
  assign evt.rdEnd = !rdCmd && rdCmdD1;   // read strobe released
  assign evt.data  = iadQ;

  assign readActive = rdCmd;

endmodule

`default_nettype wire

/* logic/idmaPkg.sv */
`default_nettype none

package idmaPkg;

  localparam int addrBits = 14;
  localparam int hostBits = 16;  // multiplexed host bus
  localparam int wordBits = 24;  // PM word with DM in the upper 16

  // bit 14 of the control word
  typedef enum logic {
    tgtPm,
    tgtDm
  } memTarget;

  typedef enum logic [1:0] {
    sIdle,
    sHostWait,
    sSteal,
    sDone
  } seqState;

  // one-cycle pulses from the host side
  typedef struct packed {
    logic                latch;
    logic                rdBeg;
    logic                wrBeg;
    logic                rdEnd;
    logic [hostBits-1:0] data;
  } hostEvt;

  typedef struct packed {
    logic                req;     // level held until ack
    logic                we;
    memTarget            target;
    logic [addrBits-1:0] addr;
    logic [wordBits-1:0] wdata;
  } memReq;

  typedef struct packed {
    logic                ack;     // single cycle
    logic [wordBits-1:0] rdata;
  } memRsp;

endpackage

`default_nettype wire

/* logic/idmaPort.sv */
`timescale 1ns/1ps
`default_nettype none

module idmaPort #(
  parameter int hostWait = 3,
  parameter int memWords = 256
) (
  input  logic                         DSPCLK,
  input  logic                         RST,
  input  logic                         coreIdle,
  input  logic                         ISn,
  input  logic                         IRDn,
  input  logic                         IWRn,
  input  logic                         IAL,
  input  logic [idmaPkg::hostBits-1:0] IAD,
  output logic [idmaPkg::hostBits-1:0] IADout,
  output logic                         IADoe,
  output logic                         IACKn
);

  idmaPkg::hostEvt evt;
  idmaPkg::memReq  req;
  idmaPkg::memRsp  rsp;
  logic            readActive;

  hostSync uSync (
    .DSPCLK     (DSPCLK),
    .RST        (RST),
    .ISn        (ISn),
    .IRDn       (IRDn),
    .IWRn       (IWRn),
    .IAL        (IAL),
    .IAD        (IAD),
    .evt        (evt),
    .readActive (readActive)
  );

  idmaSequencer #(
    .hostWait (hostWait)
  ) uSeq (
    .DSPCLK     (DSPCLK),
    .RST        (RST),
    .evt        (evt),
    .req        (req),
    .rsp        (rsp),
    .readActive (readActive),
    .IACKn      (IACKn),
    .IADout     (IADout),
    .IADoe      (IADoe)
  );

  memSteal #(
    .memWords (memWords)
  ) uMem (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .coreIdle (coreIdle),
    .req      (req),
    .rsp      (rsp)
  );

endmodule

`default_nettype wire

/* logic/idmaSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module idmaSequencer #(
  parameter int hostWait = 3
) (
  input  logic                         DSPCLK,
  input  logic                         RST,
  input  idmaPkg::hostEvt              evt,
  output idmaPkg::memReq               req,
  input  idmaPkg::memRsp               rsp,
  input  logic                         readActive,
  output logic                         IACKn,
  output logic [idmaPkg::hostBits-1:0] IADout,
  output logic                         IADoe
);

  idmaPkg::seqState             state;
  idmaPkg::memTarget            target;
  logic [idmaPkg::addrBits-1:0] addr;
  logic [idmaPkg::wordBits-1:0] stage;
  logic [2:0]                   waitCnt;
  logic pmFirst;   // next PM half is the upper 16 bits
  logic rdOp;
  logic rdHeld;    // read strobe still low
  logic outLow;    // bus shows the low PM byte
  logic reqOn;
  logic beg;
  logic useMem;
  logic done;
  logic upHalf;

  assign beg = evt.rdBeg || evt.wrBeg;

  // PM first read half and second write half go to memory
  assign useMem = (target == idmaPkg::tgtDm) || (evt.rdBeg ? pmFirst : !pmFirst);

  assign done = (state == idmaPkg::sSteal && rsp.ack) ||
                (state == idmaPkg::sHostWait && waitCnt == 3'd0);

  assign upHalf = (target == idmaPkg::tgtDm) || pmFirst;

  // control register holds target and address
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      target <= idmaPkg::tgtPm;
      addr   <= '0;
    end else if (evt.latch) begin
      target <= idmaPkg::memTarget'(evt.data[14]);
      addr   <= evt.data[idmaPkg::addrBits-1:0];
    end else if (done && !upHalf) begin
      addr <= addr + 1'b1;   // PM word complete
    end else if (done && target == idmaPkg::tgtDm) begin
      addr <= addr + 1'b1;
    end
  end

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      pmFirst <= 1'b1;
    end else if (evt.latch) begin
      pmFirst <= 1'b1;
    end else if (done && target == idmaPkg::tgtPm) begin
      pmFirst <= !pmFirst;
    end
  end

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      state   <= idmaPkg::sIdle;
      reqOn   <= 1'b0;
      IACKn   <= 1'b0;
      waitCnt <= '0;
      rdOp    <= 1'b0;
    end else begin
      case (state)
        idmaPkg::sIdle: begin
          if (beg) begin
            IACKn <= 1'b1;
            rdOp  <= evt.rdBeg;
            if (useMem) begin
              reqOn <= 1'b1;
              state <= idmaPkg::sSteal;
            end else begin
              waitCnt <= 3'(hostWait);
              state   <= idmaPkg::sHostWait;
            end
          end
        end
        idmaPkg::sSteal: begin
          if (rsp.ack) begin
            reqOn <= 1'b0;
            IACKn <= 1'b0;
            state <= idmaPkg::sDone;
          end
        end
        idmaPkg::sHostWait: begin
          if (waitCnt == 3'd0) begin
            IACKn <= 1'b0;
            state <= idmaPkg::sDone;
          end else begin
            waitCnt <= waitCnt - 1'b1;
          end
        end
        idmaPkg::sDone: begin
          if (!rdHeld || evt.rdEnd) begin   // reads wait for strobe release
            state <= idmaPkg::sIdle;
          end
        end
        default: state <= idmaPkg::sIdle;
      endcase
    end
  end

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      rdHeld <= 1'b0;
    end else if (evt.rdBeg) begin
      rdHeld <= 1'b1;
    end else if (evt.rdEnd) begin
      rdHeld <= 1'b0;
    end
  end

  // half shown on the bus is fixed when the read starts
  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      outLow <= 1'b0;
    end else if (evt.latch) begin
      outLow <= 1'b0;
    end else if (evt.rdBeg) begin
      outLow <= !upHalf;
    end
  end

  // staging word with DM data in the upper 16 bits
  always_ff @(posedge DSPCLK) begin
    if (evt.wrBeg && upHalf) begin
      stage[23:8] <= evt.data;
    end else if (evt.wrBeg) begin
      stage[7:0] <= evt.data[7:0];
    end else if (rsp.ack && rdOp) begin
      stage <= rsp.rdata;
    end
  end

  assign req.req    = reqOn;
  assign req.we     = !rdOp;
  assign req.target = target;
  assign req.addr   = addr;
  assign req.wdata  = stage;

  assign IADout = outLow ? {8'h00, stage[7:0]} : stage[23:8];
  assign IADoe  = readActive || (rdOp && state != idmaPkg::sIdle);

endmodule

`default_nettype wire

/* logic/memSteal.sv */
`timescale 1ns/1ps
`default_nettype none

module memSteal #(
  parameter int memWords = 256
) (
  input  logic            DSPCLK,
  input  logic            RST,
  input  logic            coreIdle,
  input  idmaPkg::memReq  req,
  output idmaPkg::memRsp  rsp
);

  localparam int idxBits = $clog2(memWords);

  logic [15:0]                  dmArr [memWords];
  logic [idmaPkg::wordBits-1:0] pmArr [memWords];
  logic [idxBits-1:0]           idx;
  logic [idmaPkg::wordBits-1:0] rdata;
  logic                         ack;
  logic                         grant;

  assign idx = req.addr[idxBits-1:0];   // upper address bits ignored

  // no re-grant while ack is out since req drops the cycle after
  assign grant = req.req && coreIdle && !ack;

  always_ff @(posedge DSPCLK or posedge RST) begin
    if (RST) begin
      ack <= 1'b0;
    end else begin
      ack <= grant;
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (grant) begin
      if (req.target == idmaPkg::tgtDm) begin
        if (req.we) begin
          dmArr[idx] <= req.wdata[23:8];
        end
        rdata <= {dmArr[idx], 8'h00};
      end else begin
        if (req.we) begin
          pmArr[idx] <= req.wdata;
        end
        rdata <= pmArr[idx];
      end
    end
  end

  assign rsp.ack   = ack;
  assign rsp.rdata = rdata;

endmodule

`default_nettype wire

/* tb/idmaTb.sv */
`timescale 1ns/1ps
`default_nettype none

module idmaTb;

  localparam int numSteps    = 29;
  localparam int cycleLimit  = numSteps * 40;
  localparam int stallCycles = 8;   // cycles with the core busy

  typedef enum logic [2:0] {
    opLatch,
    opWrite,
    opRead,
    opStallWrite,
    opStallRead
  } hostOp;

  typedef struct packed {
    hostOp       op;
    logic [15:0] value;
    logic [15:0] expVal;   // only used by reads
  } stepT;

  logic        DSPCLK;
  logic        RST;
  logic        coreIdle;
  logic        ISn;
  logic        IRDn;
  logic        IWRn;
  logic        IAL;
  logic [15:0] IAD;
  logic [15:0] IADout;
  logic        IADoe;
  logic        IACKn;

  logic        holdLow;   // forces coreIdle low
  int          errCnt;
  int          checkCnt;
  int          cycleCnt;
  stepT        steps [numSteps];

  idmaPort #(
    .hostWait (3),
    .memWords (256)
  ) dut (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .coreIdle (coreIdle),
    .ISn      (ISn),
    .IRDn     (IRDn),
    .IWRn     (IWRn),
    .IAL      (IAL),
    .IAD      (IAD),
    .IADout   (IADout),
    .IADoe    (IADoe),
    .IACKn    (IACKn)
  );

  initial begin
    DSPCLK = 1'b0;
    forever #20 DSPCLK = ~DSPCLK;
  end

  // random core idle unless a stall test holds it low
  initial begin
    int seedVal;
    seedVal  = $urandom(32'h5aed);
    coreIdle = 1'b1;
    forever begin
      @(negedge DSPCLK);
      if (holdLow) begin
        coreIdle = 1'b0;
      end else begin
        coreIdle = ($urandom % 4) != 0;
      end
    end
  end

  initial begin
    cycleCnt = 0;
    while (cycleCnt < cycleLimit) begin
      @(posedge DSPCLK);
      cycleCnt = cycleCnt + 1;
    end
    $display("timeout: the host port stopped responding after %0d cycles", cycleCnt);
    $display("TEST FAIL");
    $finish;
  end

  function automatic stepT makeStep(hostOp op, logic [15:0] value, logic [15:0] expVal);
    stepT s;
    s.op     = op;
    s.value  = value;
    s.expVal = expVal;
    return s;
  endfunction

  task automatic loadTable();
    // DM words from address 5 then read back in order
    steps[0]  = makeStep(opLatch, 16'h4005, 16'h0000);
    steps[1]  = makeStep(opWrite, 16'h1234, 16'h0000);
    steps[2]  = makeStep(opWrite, 16'hbeef, 16'h0000);
    steps[3]  = makeStep(opWrite, 16'h0a5c, 16'h0000);
    steps[4]  = makeStep(opLatch, 16'h4005, 16'h0000);
    steps[5]  = makeStep(opRead,  16'h0000, 16'h1234);
    steps[6]  = makeStep(opRead,  16'h0000, 16'hbeef);
    steps[7]  = makeStep(opRead,  16'h0000, 16'h0a5c);
    // PM words as upper 16 then low 8 (upper byte of the low half dropped)
    steps[8]  = makeStep(opLatch, 16'h0005, 16'h0000);
    steps[9]  = makeStep(opWrite, 16'habcd, 16'h0000);
    steps[10] = makeStep(opWrite, 16'h7712, 16'h0000);
    steps[11] = makeStep(opWrite, 16'h5a5a, 16'h0000);
    steps[12] = makeStep(opWrite, 16'h33c3, 16'h0000);
    steps[13] = makeStep(opLatch, 16'h0005, 16'h0000);
    steps[14] = makeStep(opRead,  16'h0000, 16'habcd);
    steps[15] = makeStep(opRead,  16'h0000, 16'h0012);
    steps[16] = makeStep(opRead,  16'h0000, 16'h5a5a);
    steps[17] = makeStep(opRead,  16'h0000, 16'h00c3);
    // one address step per 24-bit word
    steps[18] = makeStep(opLatch, 16'h0006, 16'h0000);
    steps[19] = makeStep(opRead,  16'h0000, 16'h5a5a);
    steps[20] = makeStep(opRead,  16'h0000, 16'h00c3);
    // DM at the same addresses is untouched by the PM writes
    steps[21] = makeStep(opLatch, 16'h4005, 16'h0000);
    steps[22] = makeStep(opRead,  16'h0000, 16'h1234);
    steps[23] = makeStep(opLatch, 16'h4006, 16'h0000);
    steps[24] = makeStep(opRead,  16'h0000, 16'hbeef);
    // core busy during DM accesses
    steps[25] = makeStep(opLatch,      16'h4010, 16'h0000);
    steps[26] = makeStep(opStallWrite, 16'hc0de, 16'h0000);
    steps[27] = makeStep(opLatch,      16'h4010, 16'h0000);
    steps[28] = makeStep(opStallRead,  16'h0000, 16'hc0de);
  endtask

  task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] expVal);
    checkCnt = checkCnt + 1;
    if (got !== expVal) begin
      errCnt = errCnt + 1;
      $display("error %s: got %h, expected %h", name, got, expVal);
    end
  endtask

  // poll the busy flag on falling edges
  task automatic waitReady();
    while (IACKn !== 1'b0) begin
      @(negedge DSPCLK);
    end
  endtask

  task automatic driveStrobe(input logic isRead, input logic [15:0] value);
    ISn  = 1'b0;
    IRDn = !isRead;
    IWRn = isRead;
    IAD  = value;
    repeat (2) @(negedge DSPCLK);
    ISn  = 1'b1;
    IRDn = 1'b1;
    IWRn = 1'b1;
  endtask

  task automatic latchAddr(input logic [15:0] ctrl);
    waitReady();
    ISn = 1'b0;
    IAL = 1'b1;
    IAD = ctrl;   // bit 14 selects DM
    repeat (2) @(negedge DSPCLK);
    ISn = 1'b1;
    IAL = 1'b0;
    @(negedge DSPCLK);
  endtask

  task automatic hostWrite(input logic [15:0] value);
    waitReady();
    driveStrobe(1'b0, value);
  endtask

  task automatic hostRead(input logic [15:0] expVal);
    waitReady();
    driveStrobe(1'b1, 16'h0000);
    waitReady();   // data is on the bus once the flag drops
    checkVal("IADout", IADout, expVal);
    checkVal("IADoe", {15'h0, IADoe}, 16'h0001);
  endtask

  task automatic stalledAccess(input logic isRead, input logic [15:0] value,
                               input logic [15:0] expVal);
    waitReady();
    holdLow = 1'b1;
    repeat (2) @(negedge DSPCLK);
    driveStrobe(isRead, value);
    repeat (stallCycles) begin
      @(negedge DSPCLK);
      checkVal("IACKn", {15'h0, IACKn}, 16'h0001);
    end
    holdLow = 1'b0;
    waitReady();
    if (isRead) begin
      checkVal("IADout", IADout, expVal);
    end
  endtask

  initial begin
    int i;
    errCnt   = 0;
    checkCnt = 0;
    holdLow  = 1'b0;
    RST      = 1'b1;
    ISn      = 1'b1;
    IRDn     = 1'b1;
    IWRn     = 1'b1;
    IAL      = 1'b0;
    IAD      = 16'h0000;
    loadTable();

    repeat (4) @(negedge DSPCLK);
    RST = 1'b0;
    @(negedge DSPCLK);
    checkVal("IACKn", {15'h0, IACKn}, 16'h0000);   // ready after reset
    checkVal("IADoe", {15'h0, IADoe}, 16'h0000);

    for (i = 0; i < numSteps; i++) begin
      case (steps[i].op)
        opLatch:      latchAddr(steps[i].value);
        opWrite:      hostWrite(steps[i].value);
        opRead:       hostRead(steps[i].expVal);
        opStallWrite: stalledAccess(1'b0, steps[i].value, steps[i].expVal);
        opStallRead:  stalledAccess(1'b1, steps[i].value, steps[i].expVal);
        default: begin
          errCnt = errCnt + 1;
          $display("step %0d has an unknown operation", i);
        end
      endcase
    end
    waitReady();

    $display("checks %0d, errors %0d", checkCnt, errCnt);
    if (errCnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
